// File: source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int way_num_lp     = 4;
    localparam int way_bits_lp    = 2;
    localparam int line_words_lp  = 8;   // also the burst length
    localparam int word_bits_lp   = 3;
    localparam int index_bits_lp  = 4;
    localparam int set_num_lp     = 16;
    localparam int offset_bits_lp = 5;   // byte offset inside a line
    localparam int tag_bits_lp    = 23;

    localparam logic [3:0] burst_len_lp = 4'd7;   // arlen / awlen

    typedef logic [way_bits_lp-1:0]   way_t;
    typedef logic [index_bits_lp-1:0] index_t;
    typedef logic [tag_bits_lp-1:0]   tag_t;
    typedef logic [word_bits_lp-1:0]  word_sel_t;

    // processor access, wen of zero is a load
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  wen;
        logic [31:0] wdata;
    } cpu_req_t;

    // burst address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  len;
    } axi_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
        logic        valid;
    } axi_rbeat_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
        logic        valid;
    } axi_wbeat_t;

endpackage

`default_nettype wire

// File: source/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store (
    input  wire                 clk,
    input  wire                 rst,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::tag_t    tag,
    input  wire                 lookup_done,
    input  wire                 is_store,
    input  wire                 install,
    output logic                hit,
    output dcache_pkg::way_t    hit_way,
    output dcache_pkg::way_t    victim_way,
    output dcache_pkg::tag_t    victim_tag,
    output logic                victim_dirty
);
    import dcache_pkg::*;

    logic [way_num_lp-1:0] valid_q [set_num_lp];
    logic [way_num_lp-1:0] dirty_q [set_num_lp];
    logic [2:0]            plru_q  [set_num_lp];   // tree bits, bit 0 is the root
    tag_t                  tag_q   [way_num_lp][set_num_lp];

    logic [way_num_lp-1:0] match;
    logic [2:0]            plru;

    // hit detection across the ways
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < way_num_lp; w++) begin
            match[w] = valid_q[index][w] && (tag_q[w][index] == tag);
            if (match[w])
                hit_way = way_t'(w);
        end
    end

    assign hit = |match;

    // victim from the pseudo-LRU tree
    assign plru         = plru_q[index];
    assign victim_way   = {plru[0], plru[0] ? plru[2] : plru[1]};
    assign victim_tag   = tag_q[victim_way][index];
    assign victim_dirty = valid_q[index][victim_way] & dirty_q[index][victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < set_num_lp; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else if (install) begin
            valid_q[index][victim_way] <= 1'b1;
            dirty_q[index][victim_way] <= 1'b0;   // fresh line from memory
        end else if (lookup_done) begin
            plru_q[index][0] <= ~hit_way[1];
            if (!hit_way[1])
                plru_q[index][1] <= ~hit_way[0];
            else
                plru_q[index][2] <= ~hit_way[0];
            if (is_store)
                dirty_q[index][hit_way] <= 1'b1;
        end
    end

    // tag array, only written on install
    always_ff @(posedge clk) begin
        if (install)
            tag_q[victim_way][index] <= tag;
    end

endmodule

`default_nettype wire

// File: source/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store (
    input  wire                    clk,
    input  dcache_pkg::index_t     index,
    input  dcache_pkg::word_sel_t  word,
    input  dcache_pkg::way_t       hit_way,
    input  wire                    store_en,
    input  wire [3:0]              wen,
    input  wire [31:0]             wdata,
    input  wire                    fill_en,
    input  dcache_pkg::way_t       fill_way,
    input  dcache_pkg::word_sel_t  fill_word,
    input  wire [31:0]             fill_data,
    input  dcache_pkg::word_sel_t  wb_word,
    output logic [31:0]            rdata,
    output logic [31:0]            wb_data
);
    import dcache_pkg::*;

    // one word per way, set and line position
    logic [31:0] mem_q [way_num_lp][set_num_lp][line_words_lp];

    assign rdata   = mem_q[hit_way][index][word];
    assign wb_data = mem_q[fill_way][index][wb_word];   // victim line going out

    always_ff @(posedge clk) begin
        if (fill_en)
            mem_q[fill_way][index][fill_word] <= fill_data;
        if (store_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wen[b])
                    mem_q[hit_way][index][word][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/miss_control.sv
`timescale 1ns/1ps
`default_nettype none

module miss_control (
    input  wire   clk,
    input  wire   rst,
    input  wire   req,
    input  wire   hit,
    input  wire   victim_dirty,
    input  wire   write_done,
    input  wire   read_done,
    output logic  stall,
    output logic  start_write,
    output logic  start_read,
    output logic  install,
    output logic  lookup_done
);

    typedef enum logic [1:0] {
        st_lookup,
        st_write_back,
        st_refill,
        st_install
    } state_t;

    state_t state;
    logic   miss;

    assign miss = (state == st_lookup) & req & ~hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_lookup;
        end else begin
            case (state)
                st_lookup: begin
                    if (miss)
                        state <= victim_dirty ? st_write_back : st_refill;
                end
                st_write_back: if (write_done) state <= st_refill;
                st_refill:     if (read_done) state <= st_install;
                default:       state <= st_lookup;   // install lasts one cycle
            endcase
        end
    end

    // start pulses land in the first cycle of their state
    always_ff @(posedge clk) begin
        if (rst) begin
            start_write <= 1'b0;
            start_read  <= 1'b0;
        end else begin
            start_write <= miss & victim_dirty;
            start_read  <= (miss & ~victim_dirty)
                         | ((state == st_write_back) & write_done);
        end
    end

    assign install     = (state == st_install);
    assign lookup_done = (state == st_lookup) & req & hit;
    assign stall       = (state != st_lookup) | (req & ~hit);

endmodule

`default_nettype wire

// File: source/axi_burst_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_master (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start_read,
    input  wire                     start_write,
    input  wire [31:0]              rd_line,
    input  wire [31:0]              wr_line,
    input  wire [31:0]              wb_data,
    output dcache_pkg::axi_addr_t   ar,
    output logic                    arvalid,
    input  wire                     arready,
    input  dcache_pkg::axi_rbeat_t  r_beat,
    output logic                    rready,
    output dcache_pkg::axi_addr_t   aw,
    output logic                    awvalid,
    input  wire                     awready,
    output dcache_pkg::axi_wbeat_t  w_beat,
    input  wire                     wready,
    input  wire                     bvalid,
    output logic                    bready,
    output dcache_pkg::word_sel_t   wb_word,
    output logic                    fill_en,
    output dcache_pkg::word_sel_t   fill_word,
    output logic [31:0]             fill_data,
    output logic                    read_done,
    output logic                    write_done
);
    import dcache_pkg::*;

    logic read_req, write_req;    // a burst is pending
    logic raddr_rcv, waddr_rcv;   // address accepted
    logic wdata_rcv;              // last write beat accepted
    word_sel_t rcnt, wcnt;        // beat counters

    logic data_back, data_go;
    logic read_finish, write_finish;

    assign data_back    = raddr_rcv & r_beat.valid & rready;
    assign data_go      = waddr_rcv & w_beat.valid & wready;
    assign read_finish  = data_back & r_beat.last;
    assign write_finish = waddr_rcv & wdata_rcv & bvalid & bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_req   <= 1'b0;
            write_req  <= 1'b0;
            raddr_rcv  <= 1'b0;
            waddr_rcv  <= 1'b0;
            wdata_rcv  <= 1'b0;
            rcnt       <= '0;
            wcnt       <= '0;
            read_done  <= 1'b0;
            write_done <= 1'b0;
        end else begin
            read_req  <= start_read ? 1'b1 : read_finish ? 1'b0 : read_req;
            write_req <= start_write ? 1'b1 : write_finish ? 1'b0 : write_req;

            raddr_rcv <= (arvalid & arready) ? 1'b1 : read_finish ? 1'b0 : raddr_rcv;
            waddr_rcv <= (awvalid & awready) ? 1'b1 : write_finish ? 1'b0 : waddr_rcv;
            wdata_rcv <= (data_go & w_beat.last) ? 1'b1 : write_finish ? 1'b0 : wdata_rcv;

            rcnt <= read_finish ? '0 : data_back ? rcnt + 1'b1 : rcnt;
            wcnt <= write_finish ? '0 : data_go ? wcnt + 1'b1 : wcnt;

            read_done  <= read_finish;
            write_done <= write_finish;
        end
    end

    // read channel
    assign ar.addr = rd_line;
    assign ar.len  = burst_len_lp;
    assign arvalid = read_req & ~raddr_rcv;
    assign rready  = raddr_rcv;

    // each beat goes straight into the victim way
    assign fill_en   = data_back;
    assign fill_word = rcnt;
    assign fill_data = r_beat.data;

    // write channel
    assign aw.addr      = wr_line;
    assign aw.len       = burst_len_lp;
    assign awvalid      = write_req & ~waddr_rcv;
    assign wb_word      = wcnt;
    assign w_beat.data  = wb_data;
    assign w_beat.last  = (wcnt == burst_len_lp[word_bits_lp-1:0]);
    assign w_beat.valid = waddr_rcv & ~wdata_rcv;
    assign bready       = waddr_rcv;

endmodule

`default_nettype wire

// File: source/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     req,
    input  dcache_pkg::cpu_req_t    cpu_req,
    output logic [31:0]             rdata,
    output logic                    stall,
    output dcache_pkg::axi_addr_t   ar,
    output logic                    arvalid,
    input  wire                     arready,
    input  dcache_pkg::axi_rbeat_t  r_beat,
    output logic                    rready,
    output dcache_pkg::axi_addr_t   aw,
    output logic                    awvalid,
    input  wire                     awready,
    output dcache_pkg::axi_wbeat_t  w_beat,
    input  wire                     wready,
    input  wire                     bvalid,
    output logic                    bready
);
    import dcache_pkg::*;

    // address split
    tag_t      req_tag;
    index_t    req_index;
    word_sel_t req_word;

    assign req_tag   = cpu_req.addr[31 -: tag_bits_lp];
    assign req_index = cpu_req.addr[offset_bits_lp +: index_bits_lp];
    assign req_word  = cpu_req.addr[2 +: word_bits_lp];

    logic      is_store;
    logic      hit, victim_dirty, install, lookup_done;
    way_t      hit_way, victim_way;
    tag_t      victim_tag;
    logic      start_read, start_write, read_done, write_done;
    logic      fill_en;
    word_sel_t fill_word, wb_word;
    logic [31:0] fill_data, wb_data;
    logic [31:0] rd_line, wr_line;

    assign is_store = |cpu_req.wen;

    // line addresses with the offset zeroed
    assign rd_line = {req_tag, req_index, {offset_bits_lp{1'b0}}};
    assign wr_line = {victim_tag, req_index, {offset_bits_lp{1'b0}}};

    tag_store u_tag_store (
        .clk          (clk),
        .rst          (rst),
        .index        (req_index),
        .tag          (req_tag),
        .lookup_done  (lookup_done),
        .is_store     (is_store),
        .install      (install),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    data_store u_data_store (
        .clk       (clk),
        .index     (req_index),
        .word      (req_word),
        .hit_way   (hit_way),
        .store_en  (lookup_done & is_store),   // completed store only
        .wen       (cpu_req.wen),
        .wdata     (cpu_req.wdata),
        .fill_en   (fill_en),
        .fill_way  (victim_way),
        .fill_word (fill_word),
        .fill_data (fill_data),
        .wb_word   (wb_word),
        .rdata     (rdata),
        .wb_data   (wb_data)
    );

    miss_control u_miss_control (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .write_done   (write_done),
        .read_done    (read_done),
        .stall        (stall),
        .start_write  (start_write),
        .start_read   (start_read),
        .install      (install),
        .lookup_done  (lookup_done)
    );

    axi_burst_master u_axi_burst_master (
        .clk         (clk),
        .rst         (rst),
        .start_read  (start_read),
        .start_write (start_write),
        .rd_line     (rd_line),
        .wr_line     (wr_line),
        .wb_data     (wb_data),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r_beat      (r_beat),
        .rready      (rready),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w_beat      (w_beat),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready),
        .wb_word     (wb_word),
        .fill_en     (fill_en),
        .fill_word   (fill_word),
        .fill_data   (fill_data),
        .read_done   (read_done),
        .write_done  (write_done)
    );

endmodule

`default_nettype wire

// File: sim/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
    input  wire                     clk,
    input  wire                     rst,
    input  dcache_pkg::axi_addr_t   ar,
    input  wire                     arvalid,
    output logic                    arready,
    output dcache_pkg::axi_rbeat_t  r_beat,
    input  wire                     rready,
    input  dcache_pkg::axi_addr_t   aw,
    input  wire                     awvalid,
    output logic                    awready,
    input  dcache_pkg::axi_wbeat_t  w_beat,
    output logic                    wready,
    output logic                    bvalid,
    input  wire                     bready,
    output int                      read_bursts
);
    import dcache_pkg::*;

    logic [31:0] written [logic [31:0]];   // words stored by write bursts
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    int          rd_left;                  // read beats still to send
    logic        b_pend;
    logic        rst_s, ar_fire, r_fire, aw_fire, w_fire, b_fire;
    axi_addr_t   ar_s;
    axi_addr_t   aw_s;
    axi_wbeat_t  w_s;

    // untouched words follow their address
    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (written.exists(a))
            return written[a];
        return a ^ 32'hA5A5_0000;
    endfunction

    initial begin
        arready     = 1'b0;
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        r_beat      = '0;
        read_bursts = 0;
        rd_addr     = '0;
        wr_addr     = '0;
        rd_left     = 0;
        b_pend      = 1'b0;
        void'($urandom(25));
        forever begin
            // bus is settled half a cycle before the edge
            @(negedge clk);
            rst_s   = rst;
            ar_s    = ar;
            aw_s    = aw;
            w_s     = w_beat;
            ar_fire = arvalid & arready;
            r_fire  = r_beat.valid & rready;
            aw_fire = awvalid & awready;
            w_fire  = w_beat.valid & wready;
            b_fire  = bvalid & bready;
            @(posedge clk);
            #5;
            if (rst_s) begin
                rd_left = 0;
                b_pend  = 1'b0;
            end else begin
                if (ar_fire) begin
                    rd_addr = ar_s.addr;
                    rd_left = int'(ar_s.len) + 1;
                    read_bursts++;
                end
                if (r_fire) begin
                    rd_addr += 4;
                    rd_left--;
                end
                if (aw_fire)
                    wr_addr = aw_s.addr;
                if (b_fire)
                    b_pend = 1'b0;
                if (w_fire) begin
                    written[wr_addr] = w_s.data;
                    wr_addr += 4;
                    b_pend = b_pend | w_s.last;   // response after the last beat
                end
            end
            arready = ~rst_s & ($urandom % 4 != 0);   // a gap about one cycle in four
            awready = ~rst_s & ($urandom % 4 != 0);
            wready  = ~rst_s & ($urandom % 4 != 0);
            bvalid  = b_pend;
            if (rd_left == 0) begin
                r_beat = '0;
            end else if (!(r_beat.valid && !r_fire)) begin
                r_beat.valid = ($urandom % 4 != 0);
                r_beat.data  = word_at(rd_addr);
                r_beat.last  = (rd_left == 1);
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/dcache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sva (
    input wire                     clk,
    input wire                     rst,
    input wire                     stall,
    input dcache_pkg::axi_addr_t   ar,
    input wire                     arvalid,
    input wire                     arready,
    input wire                     rready,
    input dcache_pkg::axi_addr_t   aw,
    input wire                     awvalid,
    input wire                     awready,
    input dcache_pkg::axi_wbeat_t  w_beat,
    input wire                     wready,
    input wire                     bready
);
    int assert_fails = 0;

    // a raised valid waits for its ready with the payload held
    ar_held: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            assert_fails++;
            $error("arvalid or ar changed before arready");
        end

    aw_held: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            assert_fails++;
            $error("awvalid or aw changed before awready");
        end

    w_held: assert property (@(posedge clk) disable iff (rst)
        w_beat.valid && !wready |=> w_beat.valid && $stable(w_beat.data))
        else begin
            assert_fails++;
            $error("write beat changed before wready");
        end

    // the processor waits while any burst is under way
    stall_on_burst: assert property (@(posedge clk) disable iff (rst)
        (arvalid || awvalid || w_beat.valid || rready || bready) |-> stall)
        else begin
            assert_fails++;
            $error("stall low during a burst");
        end

    one_address: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && awvalid))
        else begin
            assert_fails++;
            $error("arvalid and awvalid high together");
        end

endmodule

bind dcache_top dcache_sva u_sva (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready),
    .rready  (rready),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w_beat  (w_beat),
    .wready  (wready),
    .bready  (bready)
);

`default_nettype wire

// File: sim/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    // one line of the input file
    typedef struct packed {
        logic [3:0]  op;      // 0 load, 1 store, f past the end
        logic [31:0] addr;
        logic [3:0]  wen;
        logic [31:0] wdata;
        logic [31:0] rdata;   // expected on loads
        logic [7:0]  reads;   // read bursts so far
    } test_vec_t;

    logic        clk;
    logic        rst;
    logic        req;
    cpu_req_t    cpu_req;
    logic [31:0] rdata;
    logic        stall;
    axi_addr_t   ar;
    axi_addr_t   aw;
    axi_rbeat_t  r_beat;
    axi_wbeat_t  w_beat;
    logic        arvalid, arready, rready;
    logic        awvalid, awready, wready;
    logic        bvalid, bready;
    int          read_bursts;

    logic [111:0] vectors [64];
    int           n_tests;
    int           errors;
    int           last_reads;   // expected read bursts after the previous line

    dcache_top uut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .cpu_req (cpu_req),
        .rdata   (rdata),
        .stall   (stall),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r_beat  (r_beat),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w_beat  (w_beat),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    axi_mem_model u_mem (
        .clk         (clk),
        .rst         (rst),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r_beat      (r_beat),
        .rready      (rready),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w_beat      (w_beat),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready),
        .read_bursts (read_bursts)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    // every burst moves one whole line
    always @(negedge clk) begin
        if (arvalid)
            check_value("ar.len", 32'(ar.len), line_words_lp - 1);
        if (awvalid)
            check_value("aw.len", 32'(aw.len), line_words_lp - 1);
    end

    // one access from posedge plus 5 ns until it completes
    task automatic run_access(input int n);
        test_vec_t   tv;
        logic [31:0] got_rdata;
        int          got_reads;
        int          errs_before;
        logic        expect_miss;
        tv = test_vec_t'(vectors[n]);
        errs_before = errors;
        expect_miss = (int'(tv.reads) != last_reads);   // a miss costs one read burst
        req = 1'b1;
        cpu_req.addr  = tv.addr;
        cpu_req.wen   = tv.wen;
        cpu_req.wdata = tv.wdata;
        @(negedge clk);
        check_value("stall", 32'(stall), 32'(expect_miss));   // hits never stall
        while (stall)
            @(negedge clk);   // miss still being served
        got_rdata = rdata;
        got_reads = read_bursts;
        @(posedge clk);       // access completes on this edge
        #5;
        if (tv.op == 4'h0)
            check_value("rdata", got_rdata, tv.rdata);
        check_value("read_bursts", 32'(got_reads), 32'(tv.reads));
        last_reads = int'(tv.reads);
        $display("test %0d %s %h: %s", n + 1, (tv.op == 4'h0) ? "load " : "store",
                 tv.addr, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst = 1'b1;
        req = 1'b0;
        cpu_req = '0;
        errors = 0;
        n_tests = 0;
        last_reads = 0;
        for (int i = 0; i < 64; i++)
            vectors[i] = '1;
        $readmemh("sim/dcache_input.txt", vectors);
        while (n_tests < 64 && vectors[n_tests][111:108] != 4'hf)
            n_tests++;
        if (n_tests == 0) begin
            $display("no test lines could be read from sim/dcache_input.txt");
            errors++;
        end
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        for (int i = 0; i < n_tests; i++)
            run_access(i);
        req = 1'b0;
        $display("%0d tests, %0d check errors, %0d assertion failures",
                 n_tests, errors, uut.u_sva.assert_fails);
        if (errors == 0 && uut.u_sva.assert_fails == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog with 200 cycles per access
    initial begin
        wait (rst === 1'b0 && n_tests != 0);
        #(n_tests * 200 * 100);
        $display("watchdog expired because an access never completed");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/dcache_input.txt
// columns in hex are op addr wen wdata expected_rdata read_bursts
// op 0 loads and op 1 stores, expected_rdata only checked on loads
0_00001000_0_00000000_a5a51000_01
0_0000101c_0_00000000_a5a5101c_01
1_00001004_3_12345678_00000000_01
0_00001004_0_00000000_a5a55678_01
1_00001008_8_deadbeef_00000000_01
0_00001008_0_00000000_dea51008_01
// four dirty lines in set 3 then a fifth tag
1_00002060_f_11111111_00000000_02
1_00002264_f_22222222_00000000_03
1_00002468_6_33333333_00000000_04
1_0000266c_f_44444444_00000000_05
0_00002870_0_00000000_a5a52870_06
0_00002060_0_00000000_11111111_07
0_00002264_0_00000000_22222222_08
// tree replacement in set 5
0_000040a0_0_00000000_a5a540a0_09
0_000042a4_0_00000000_a5a542a4_0a
0_000044a8_0_00000000_a5a544a8_0b
0_000046ac_0_00000000_a5a546ac_0c
0_000040bc_0_00000000_a5a540bc_0c
0_000048b0_0_00000000_a5a548b0_0d
0_000040a0_0_00000000_a5a540a0_0d
0_000042a4_0_00000000_a5a542a4_0e

// File: compile.f
source/dcache_pkg.sv
source/tag_store.sv
source/data_store.sv
source/miss_control.sv
source/axi_burst_master.sv
source/dcache_top.sv
sim/axi_mem_model.sv
sim/dcache_sva.sv
sim/tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
